// File: rtl/core_pkg.sv
`default_nettype none

package core_pkg;

  //////////////////////////////////////////////////
  // Widths

  localparam int XLEN = 32;

  typedef logic [4:0] rsd_t;                   // Register index

  //////////////////////////////////////////////////
  // Instruction word views

  typedef struct packed {
    logic [6:0] funct7;
    rsd_t       rs2;
    rsd_t       rs1;
    logic [2:0] funct3;
    rsd_t       rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm;
    rsd_t        rs1;
    logic [2:0]  funct3;
    rsd_t        rd;
    logic [6:0]  opcode;
  } i_type_t;

  typedef struct packed {
    logic [19:0] imm;                          // Upper immediate
    rsd_t        rd;
    logic [6:0]  opcode;
  } u_type_t;

  typedef union packed {
    r_type_t r;
    i_type_t i;
    u_type_t u;
  } insn_t;

  // Major opcodes still decoded
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLT,                                   // Signed compare
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_PASSB                                  // LUI
  } alu_op_t;

endpackage

`default_nettype wire

// File: rtl/core_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// Pre-decode to decode
interface pd_id_if;
  logic                      valid;            // One cycle strobe
  core_pkg::alu_op_t         op;
  logic                      use_imm;
  logic [core_pkg::XLEN-1:0] imm;
  core_pkg::rsd_t            rs1;
  core_pkg::rsd_t            rs2;
  core_pkg::rsd_t            rd;
  logic                      illegal;

  modport pd (
    output valid, op, use_imm, imm, rs1, rs2, rd, illegal
  );

  modport id (
    input  valid, op, use_imm, imm, rs1, rs2, rd, illegal
  );
endinterface

// Register file read ports
interface rf_rd_if;
  core_pkg::rsd_t            src1;
  core_pkg::rsd_t            src2;
  logic [core_pkg::XLEN-1:0] q1;               // Valid in same cycle as src1
  logic [core_pkg::XLEN-1:0] q2;

  modport id (
    output src1, src2,
    input  q1, q2
  );

  modport rf (
    input  src1, src2,
    output q1, q2
  );
endinterface

`default_nettype wire

// File: rtl/rv_pd.sv
`timescale 1ns/1ps
`default_nettype none

module rv_pd #(
  parameter int RF_REGS = 32
)
(
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            imem_valid_i,
  input  core_pkg::insn_t imem_parcel_i,
  pd_id_if.pd             pd_o
);

  core_pkg::alu_op_t         op_d;
  logic                      use_imm_d;
  logic [core_pkg::XLEN-1:0] imm_d;
  core_pkg::rsd_t            rs1_d;
  core_pkg::rsd_t            rs2_d;
  core_pkg::rsd_t            rd_d;
  logic                      bad_enc;
  logic                      reg_bad;

  //////////////////////////////////////////////////
  // Classify parcel

  always_comb
  begin
    op_d      = core_pkg::ALU_ADD;
    use_imm_d = 1'b0;
    imm_d     = '0;
    rs1_d     = imem_parcel_i.r.rs1;
    rs2_d     = '0;                            // Only OP reads rs2
    rd_d      = imem_parcel_i.r.rd;
    bad_enc   = 1'b0;

    case (imem_parcel_i.r.opcode)
      core_pkg::OPC_OP_IMM:
      begin
        use_imm_d = 1'b1;
        rs1_d     = imem_parcel_i.i.rs1;
        imm_d     = {{20{imem_parcel_i.i.imm[11]}}, imem_parcel_i.i.imm};
        case (imem_parcel_i.i.funct3)
          3'b000: op_d = core_pkg::ALU_ADD;
          3'b010: op_d = core_pkg::ALU_SLT;
          3'b100: op_d = core_pkg::ALU_XOR;
          3'b110: op_d = core_pkg::ALU_OR;
          3'b111: op_d = core_pkg::ALU_AND;
          3'b001:
          begin
            op_d    = core_pkg::ALU_SLL;
            bad_enc = imem_parcel_i.i.imm[11:5] != 7'h00;
          end
          3'b101:
          begin
            op_d    = core_pkg::ALU_SRL;
            bad_enc = imem_parcel_i.i.imm[11:5] != 7'h00; // SRAI rejected here
          end
          default: bad_enc = 1'b1;             // SLTIU
        endcase
      end

      core_pkg::OPC_OP:
      begin
        rs2_d = imem_parcel_i.r.rs2;
        case ({imem_parcel_i.r.funct7, imem_parcel_i.r.funct3})
          {7'h00, 3'b000}: op_d = core_pkg::ALU_ADD;
          {7'h20, 3'b000}: op_d = core_pkg::ALU_SUB;
          {7'h00, 3'b010}: op_d = core_pkg::ALU_SLT;
          {7'h00, 3'b100}: op_d = core_pkg::ALU_XOR;
          {7'h00, 3'b110}: op_d = core_pkg::ALU_OR;
          {7'h00, 3'b111}: op_d = core_pkg::ALU_AND;
          {7'h00, 3'b001}: op_d = core_pkg::ALU_SLL;
          {7'h00, 3'b101}: op_d = core_pkg::ALU_SRL;
          default:         bad_enc = 1'b1;
        endcase
      end

      core_pkg::OPC_LUI:
      begin
        op_d      = core_pkg::ALU_PASSB;
        use_imm_d = 1'b1;
        rs1_d     = '0;
        imm_d     = {imem_parcel_i.u.imm, 12'h000};
      end

      default: bad_enc = 1'b1;
    endcase
  end

  // Unused sources are zero, so checking all three is safe
  assign reg_bad = (32'(rd_d)  >= RF_REGS) ||
                   (32'(rs1_d) >= RF_REGS) ||
                   (32'(rs2_d) >= RF_REGS);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      pd_o.valid <= 1'b0;
    else
      pd_o.valid <= imem_valid_i;
  end

  always_ff @(posedge clk_i)
  begin
    pd_o.op      <= op_d;
    pd_o.use_imm <= use_imm_d;
    pd_o.imm     <= imm_d;
    pd_o.rs1     <= rs1_d;
    pd_o.rs2     <= rs2_d;
    pd_o.rd      <= rd_d;
    pd_o.illegal <= bad_enc | reg_bad;
  end

endmodule

`default_nettype wire

// File: rtl/rv_id.sv
`timescale 1ns/1ps
`default_nettype none

module rv_id (
  input  logic                      clk_i,
  input  logic                      rst_i,
  pd_id_if.id                       pd_i,
  rf_rd_if.id                       rf_o,

  // Write-back for the bypass
  input  logic                      ex_we_i,
  input  core_pkg::rsd_t            ex_dst_i,
  input  logic [core_pkg::XLEN-1:0] ex_r_i,

  output logic                      id_valid_o,
  output core_pkg::alu_op_t         id_op_o,
  output logic [core_pkg::XLEN-1:0] id_opa_o,
  output logic [core_pkg::XLEN-1:0] id_opb_o,
  output core_pkg::rsd_t            id_rd_o,
  output logic                      id_illegal_o
);

  logic [core_pkg::XLEN-1:0] src_a;
  logic [core_pkg::XLEN-1:0] src_b;
  logic [core_pkg::XLEN-1:0] opa_q;
  logic [core_pkg::XLEN-1:0] opb_q;
  logic                      ex_busy;
  logic                      near_a;
  logic                      near_b;
  logic                      near_a_q;
  logic                      near_b_q;

  assign rf_o.src1 = pd_i.rs1;
  assign rf_o.src2 = pd_i.rs2;

  // Result written this cycle is not yet visible in the register file
  assign src_a = (ex_we_i && ex_dst_i == pd_i.rs1) ? ex_r_i : rf_o.q1;
  assign src_b = (ex_we_i && ex_dst_i == pd_i.rs2) ? ex_r_i : rf_o.q2;

  //////////////////////////////////////////////////
  // Dependency on the instruction now in execute
  //
  // Its result lands on ex_r_i one cycle later, exactly when
  // this instruction reaches the ALU, so only a flag is kept

  assign ex_busy = id_valid_o & ~id_illegal_o & (id_rd_o != '0);
  assign near_a  = ex_busy && (id_rd_o == pd_i.rs1);
  assign near_b  = ex_busy && !pd_i.use_imm && (id_rd_o == pd_i.rs2);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      id_valid_o <= 1'b0;
    else
      id_valid_o <= pd_i.valid;
  end

  always_ff @(posedge clk_i)
  begin
    id_op_o      <= pd_i.op;
    id_rd_o      <= pd_i.rd;
    id_illegal_o <= pd_i.illegal;
    opa_q        <= src_a;
    opb_q        <= pd_i.use_imm ? pd_i.imm : src_b;
    near_a_q     <= near_a;
    near_b_q     <= near_b;
  end

  assign id_opa_o = near_a_q ? ex_r_i : opa_q;
  assign id_opb_o = near_b_q ? ex_r_i : opb_q;

endmodule

`default_nettype wire

// File: rtl/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile #(
  parameter int RF_REGS = 32
)
(
  input  logic                      clk_i,
  input  logic                      rst_i,
  rf_rd_if.rf                       rd_i,
  input  logic                      we_i,
  input  core_pkg::rsd_t            dst_i,
  input  logic [core_pkg::XLEN-1:0] d_i
);

  localparam int AW = $clog2(RF_REGS);

  logic [core_pkg::XLEN-1:0] regs [RF_REGS];
  logic                      hit1;
  logic                      hit2;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      for (int n = 0; n < RF_REGS; n++)
        regs[n] <= '0;
    end
    else if (we_i && dst_i != '0)                // x0 stays zero
      regs[dst_i[AW-1:0]] <= d_i;
  end

  // Out of range indices come with an illegal flag, read as zero
  assign hit1 = (rd_i.src1 != '0) && (32'(rd_i.src1) < RF_REGS);
  assign hit2 = (rd_i.src2 != '0) && (32'(rd_i.src2) < RF_REGS);

  assign rd_i.q1 = hit1 ? regs[rd_i.src1[AW-1:0]] : '0;
  assign rd_i.q2 = hit2 ? regs[rd_i.src2[AW-1:0]] : '0;

endmodule

`default_nettype wire

// File: rtl/rv_ex.sv
`timescale 1ns/1ps
`default_nettype none

module rv_ex (
  input  logic                      clk_i,
  input  logic                      rst_i,

  input  logic                      id_valid_i,
  input  core_pkg::alu_op_t         id_op_i,
  input  logic [core_pkg::XLEN-1:0] id_opa_i,
  input  logic [core_pkg::XLEN-1:0] id_opb_i,
  input  core_pkg::rsd_t            id_rd_i,
  input  logic                      id_illegal_i,

  output logic                      wb_we_o,
  output core_pkg::rsd_t            wb_dst_o,
  output logic [core_pkg::XLEN-1:0] wb_r_o,
  output logic                      illegal_o
);

  logic [core_pkg::XLEN-1:0] alu_r;
  logic [4:0]                shamt;
  logic                      lt;

  assign shamt = id_opb_i[4:0];                  // Upper bits ignored
  assign lt    = $signed(id_opa_i) < $signed(id_opb_i);

  //////////////////////////////////////////////////
  // ALU

  always_comb
  begin
    case (id_op_i)
      core_pkg::ALU_ADD:   alu_r = id_opa_i + id_opb_i;
      core_pkg::ALU_SUB:   alu_r = id_opa_i - id_opb_i;
      core_pkg::ALU_SLT:   alu_r = {{(core_pkg::XLEN-1){1'b0}}, lt};
      core_pkg::ALU_XOR:   alu_r = id_opa_i ^ id_opb_i;
      core_pkg::ALU_OR:    alu_r = id_opa_i | id_opb_i;
      core_pkg::ALU_AND:   alu_r = id_opa_i & id_opb_i;
      core_pkg::ALU_SLL:   alu_r = id_opa_i << shamt;
      core_pkg::ALU_SRL:   alu_r = id_opa_i >> shamt;
      core_pkg::ALU_PASSB: alu_r = id_opb_i;
      default:             alu_r = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Write-back register

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      wb_we_o   <= 1'b0;
      illegal_o <= 1'b0;
    end
    else
    begin
      wb_we_o   <= id_valid_i & ~id_illegal_i & (id_rd_i != '0);
      illegal_o <= id_valid_i &  id_illegal_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    wb_dst_o <= id_rd_i;
    wb_r_o   <= alu_r;
  end

endmodule

`default_nettype wire

// File: rtl/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
  parameter int RF_REGS = 32                     // 16 for an RV32E style core
)
(
  input  logic        clk_i,
  input  logic        rst_i,

  // Instruction parcels without back-pressure
  input  logic        imem_valid_i,
  input  logic [31:0] imem_parcel_i,

  // Write-back
  output logic        wb_we_o,
  output logic [4:0]  wb_dst_o,
  output logic [31:0] wb_r_o,
  output logic        illegal_o
);

  //////////////////////////////////////////////////
  // Stage links

  pd_id_if pd_id ();
  rf_rd_if rf_rd ();

  logic                      id_valid;
  core_pkg::alu_op_t         id_op;
  logic [core_pkg::XLEN-1:0] id_opa;
  logic [core_pkg::XLEN-1:0] id_opb;
  core_pkg::rsd_t            id_rd;
  logic                      id_illegal;

  rv_pd #(
    .RF_REGS       ( RF_REGS       ) )
  pd_unit (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .imem_valid_i  ( imem_valid_i  ),
    .imem_parcel_i ( imem_parcel_i ),
    .pd_o          ( pd_id         ) );

  // Operand fetch with bypass from write-back
  rv_id id_unit (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .pd_i          ( pd_id         ),
    .rf_o          ( rf_rd         ),
    .ex_we_i       ( wb_we_o       ),
    .ex_dst_i      ( wb_dst_o      ),
    .ex_r_i        ( wb_r_o        ),
    .id_valid_o    ( id_valid      ),
    .id_op_o       ( id_op         ),
    .id_opa_o      ( id_opa        ),
    .id_opb_o      ( id_opb        ),
    .id_rd_o       ( id_rd         ),
    .id_illegal_o  ( id_illegal    ) );

  rv_regfile #(
    .RF_REGS       ( RF_REGS       ) )
  int_rf (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .rd_i          ( rf_rd         ),
    .we_i          ( wb_we_o       ),
    .dst_i         ( wb_dst_o      ),
    .d_i           ( wb_r_o        ) );

  rv_ex ex_unit (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .id_valid_i    ( id_valid      ),
    .id_op_i       ( id_op         ),
    .id_opa_i      ( id_opa        ),
    .id_opb_i      ( id_opb        ),
    .id_rd_i       ( id_rd         ),
    .id_illegal_i  ( id_illegal    ),
    .wb_we_o       ( wb_we_o       ),
    .wb_dst_o      ( wb_dst_o      ),
    .wb_r_o        ( wb_r_o        ),
    .illegal_o     ( illegal_o     ) );

endmodule

`default_nettype wire

// File: bench/core_sva.sv
`timescale 1ns/1ps
`default_nettype none

module core_sva (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        imem_valid_i,
  input  logic [31:0] imem_parcel_i,
  input  logic        wb_we_o,
  input  logic [4:0]  wb_dst_o,
  input  logic        illegal_o
);

  //////////////////////////////////////////////////
  // Latency of three stages from strobe to write-back

  strobe_outcome: assert property (@(posedge clk_i) disable iff (rst_i)
    $past(imem_valid_i, 3) |-> (wb_we_o ^ illegal_o) ||
                               (!wb_we_o && !illegal_o && wb_dst_o == 5'd0))
    else $error("strobe gave neither a write, an illegal flag nor rd zero");

  strobe_dst: assert property (@(posedge clk_i) disable iff (rst_i)
    $past(imem_valid_i, 3) |-> wb_dst_o == $past(imem_parcel_i[11:7], 3))
    else $error("write-back destination differs from the parcel rd");

  no_ghost: assert property (@(posedge clk_i) disable iff (rst_i)
    (wb_we_o || illegal_o) |-> $past(imem_valid_i, 3))
    else $error("write-back output without a strobe three cycles before");

  //////////////////////////////////////////////////
  // Output rules

  we_ill_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    !(wb_we_o && illegal_o))
    else $error("write and illegal flag high together");

  no_x0_write: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_we_o |-> wb_dst_o != 5'd0)
    else $error("write enable with destination x0");

endmodule

bind rv_core core_sva sva_chk (
  .clk_i         ( clk_i         ),
  .rst_i         ( rst_i         ),
  .imem_valid_i  ( imem_valid_i  ),
  .imem_parcel_i ( imem_parcel_i ),
  .wb_we_o       ( wb_we_o       ),
  .wb_dst_o      ( wb_dst_o      ),
  .illegal_o     ( illegal_o     ) );

`default_nettype wire

// File: bench/tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core #(
  parameter int RF_REGS = 32
);

  // Each instruction takes at most 4 cycles with its idle gap
  localparam int INSN_BUDGET = 200;
  localparam int CYCLE_LIMIT = INSN_BUDGET * 4 + 50;

  typedef struct packed {
    logic        we;
    logic        ill;
    logic [4:0]  dst;
    logic [31:0] r;
  } outcome_t;

  logic        clk;
  logic        rst;
  logic        imem_valid;
  logic [31:0] imem_parcel;
  logic        wb_we;
  logic [4:0]  wb_dst;
  logic [31:0] wb_r;
  logic        illegal;

  logic [31:0] xreg [32];                        // Reference register model
  outcome_t    exp_q [$];                        // Up to 3 in flight
  logic [15:0] lfsr = 16'd54;
  int          cycles = 0;
  int          checks = 0;
  int          errors = 0;
  int          mark_checks;
  int          mark_errors;

  rv_core #(
    .RF_REGS       ( RF_REGS     ) )
  uut (
    .clk_i         ( clk         ),
    .rst_i         ( rst         ),
    .imem_valid_i  ( imem_valid  ),
    .imem_parcel_i ( imem_parcel ),
    .wb_we_o       ( wb_we       ),
    .wb_dst_o      ( wb_dst      ),
    .wb_r_o        ( wb_r        ),
    .illegal_o     ( illegal     ) );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk)
    cycles <= cycles + 1;

  initial
  begin
    wait (cycles >= CYCLE_LIMIT);
    $display("Timeout: tests still running after %0d cycles", CYCLE_LIMIT);
    $display("Result: FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // Random bits and instruction words

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++)
    begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] op_word(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, core_pkg::OPC_OP};
  endfunction

  function automatic logic [31:0] imm_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, core_pkg::OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, core_pkg::OPC_LUI};
  endfunction

  //////////////////////////////////////////////////
  // Reference model in program order

  function automatic outcome_t run_model(input logic [31:0] w);
    outcome_t    o;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic        ok;
    rd  = w[11:7];
    rs1 = w[19:15];
    rs2 = w[24:20];
    a   = xreg[rs1];
    b   = xreg[rs2];
    imm = {{20{w[31]}}, w[31:20]};
    ok  = 1'b1;
    o   = '0;
    case (w[6:0])
      7'b0110111:                                // LUI
      begin
        o.r = {w[31:12], 12'h000};
        rs1 = 5'd0;
        rs2 = 5'd0;
      end
      7'b0010011:                                // OP-IMM
      begin
        rs2 = 5'd0;
        case (w[14:12])
          3'b000: o.r = a + imm;
          3'b010: o.r = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
          3'b100: o.r = a ^ imm;
          3'b110: o.r = a | imm;
          3'b111: o.r = a & imm;
          3'b001:
          begin
            o.r = a << w[24:20];
            ok  = w[31:25] == 7'h00;
          end
          3'b101:
          begin
            o.r = a >> w[24:20];
            ok  = w[31:25] == 7'h00;             // SRAI is not kept
          end
          default: ok = 1'b0;
        endcase
      end
      7'b0110011:                                // OP keyed by funct7 and funct3
        case ({w[31:25], w[14:12]})
          10'h000: o.r = a + b;
          10'h100: o.r = a - b;
          10'h002: o.r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          10'h004: o.r = a ^ b;
          10'h006: o.r = a | b;
          10'h007: o.r = a & b;
          10'h001: o.r = a << b[4:0];
          10'h005: o.r = a >> b[4:0];
          default: ok = 1'b0;
        endcase
      default: ok = 1'b0;
    endcase
    // Unused source fields were cleared above
    if (32'(rd) >= RF_REGS || 32'(rs1) >= RF_REGS || 32'(rs2) >= RF_REGS)
      ok = 1'b0;
    o.dst = rd;
    o.ill = !ok;
    o.we  = ok && rd != 5'd0;
    if (o.we)
      xreg[rd] = o.r;
    return o;
  endfunction

  //////////////////////////////////////////////////
  // Drive and check once per cycle

  task automatic check_outcome(input outcome_t e);
    checks++;
    assert (wb_we === e.we && illegal === e.ill)
    else
    begin
      errors++;
      $display("error %0t: we %b illegal %b, expected %b %b",
               $time, wb_we, illegal, e.we, e.ill);
    end
    if (e.we)
    begin
      assert (wb_dst === e.dst && wb_r === e.r)
      else
      begin
        errors++;
        $display("error %0t: x%0d = %h, expected x%0d = %h", $time, wb_dst, wb_r, e.dst, e.r);
      end
    end
  endtask

  task automatic tick(input logic v, input logic [31:0] w);
    outcome_t e;
    @(negedge clk);
    if (exp_q.size() == 3)                       // Strobed 3 cycles ago
      check_outcome(exp_q.pop_front());
    e = '0;
    if (v)
      e = run_model(w);
    exp_q.push_back(e);
    imem_valid  = v;
    imem_parcel = w;
  endtask

  task automatic issue(input logic [31:0] w);
    tick(1'b1, w);
  endtask

  task automatic idle(input int n);
    repeat (n) tick(1'b0, 32'h0);
  endtask

  task automatic issue_alone(input logic [31:0] w);
    issue(w);
    idle(3);
  endtask

  task automatic start_test;
    mark_checks = checks;
    mark_errors = errors;
  endtask

  task automatic finish_test(input string name);
    idle(3);
    $display("%-8s %0d checks, %0d errors", name, checks - mark_checks, errors - mark_errors);
  endtask

  //////////////////////////////////////////////////
  // Tests

  task automatic imm_ops_test;
    start_test();
    issue_alone(lui_word(20'h12345, 5'd1));
    issue_alone(imm_word(12'hffb, 5'd0, 3'b000, 5'd2));     // -5
    issue_alone(imm_word(12'd100, 5'd2, 3'b000, 5'd3));
    issue_alone(imm_word(12'h000, 5'd2, 3'b010, 5'd4));     // SLTI with -5 < 0
    issue_alone(imm_word(12'hfff, 5'd3, 3'b010, 5'd5));
    issue_alone(imm_word(12'h7ff, 5'd1, 3'b100, 5'd6));
    issue_alone(imm_word(12'h0f0, 5'd2, 3'b110, 5'd7));
    issue_alone(imm_word(12'hf0f, 5'd1, 3'b111, 5'd8));
    issue_alone(imm_word(12'h004, 5'd2, 3'b001, 5'd9));
    issue_alone(imm_word(12'h01c, 5'd2, 3'b101, 5'd10));    // SRLI by 28
    finish_test("imm_ops");
  endtask

  task automatic reg_ops_test;
    logic [31:0] r;
    logic [9:0]  ops [8];
    ops = '{10'h000, 10'h100, 10'h002, 10'h004, 10'h006, 10'h007, 10'h001, 10'h005};
    start_test();
    for (int k = 1; k <= 4; k++)
    begin
      r = take_bits(20);
      issue(lui_word(r[19:0], 5'(k)));
      r = take_bits(12);
      issue(imm_word(r[11:0], 5'(k), 3'b000, 5'(k)));
    end
    issue(imm_word(12'h03f, 5'd0, 3'b000, 5'd5));           // Low five bits 31
    issue(imm_word(12'hfe3, 5'd0, 3'b000, 5'd6));           // Minus 29 with low bits 3
    for (int k = 0; k < 8; k++)
      issue(op_word(ops[k][9:3], 5'(1 + (k + 1) % 4), 5'(1 + k % 4), ops[k][2:0],
                    5'(7 + k)));
    issue(op_word(7'h20, 5'd1, 5'd0, 3'b000, 5'd15));       // 0 - x1 wraps
    issue(op_word(7'h00, 5'd5, 5'd6, 3'b010, 5'd15));
    issue(op_word(7'h00, 5'd6, 5'd5, 3'b010, 5'd15));
    issue(op_word(7'h00, 5'd5, 5'd1, 3'b001, 5'd13));
    issue(op_word(7'h00, 5'd5, 5'd2, 3'b101, 5'd14));
    issue(op_word(7'h00, 5'd6, 5'd3, 3'b001, 5'd13));
    issue(op_word(7'h00, 5'd6, 5'd4, 3'b101, 5'd14));
    issue(imm_word(12'h01f, 5'd1, 3'b101, 5'd12));
    finish_test("reg_ops");
  endtask

  task automatic bypass_test;
    start_test();
    issue(imm_word(12'd5, 5'd0, 3'b000, 5'd1));
    issue(imm_word(12'd7, 5'd1, 3'b000, 5'd1));             // x1 from execute
    issue(op_word(7'h00, 5'd1, 5'd1, 3'b000, 5'd2));
    issue(op_word(7'h20, 5'd1, 5'd2, 3'b000, 5'd3));        // x2 one back, x1 two back
    issue(op_word(7'h00, 5'd3, 5'd1, 3'b001, 5'd4));
    idle(3);
    issue(imm_word(12'd9, 5'd0, 3'b000, 5'd5));
    issue(imm_word(12'd1, 5'd0, 3'b000, 5'd6));
    issue(op_word(7'h00, 5'd6, 5'd5, 3'b100, 5'd7));
    idle(1);
    issue(op_word(7'h00, 5'd5, 5'd7, 3'b110, 5'd8));
    finish_test("bypass");
  endtask

  task automatic x0_test;
    start_test();
    issue(imm_word(12'd123, 5'd0, 3'b000, 5'd0));
    issue(op_word(7'h00, 5'd0, 5'd0, 3'b000, 5'd9));        // Right behind an x0 write
    issue(lui_word(20'habcde, 5'd0));
    issue(imm_word(12'hfff, 5'd0, 3'b000, 5'd10));
    idle(3);
    issue(op_word(7'h00, 5'd10, 5'd0, 3'b000, 5'd11));
    finish_test("x0");
  endtask

  task automatic illegal_test;
    start_test();
    issue(32'h0000_2083);                                   // LW
    issue(32'h0000_0000);
    issue(op_word(7'h20, 5'd2, 5'd1, 3'b101, 5'd3));        // SRA
    issue(imm_word(12'h403, 5'd1, 3'b101, 5'd3));           // SRAI
    issue(op_word(7'h00, 5'd2, 5'd1, 3'b011, 5'd0));        // SLTU to x0
    issue(imm_word(12'h005, 5'd0, 3'b000, 5'd17));          // Past x15 with 16 registers
    issue(op_word(7'h00, 5'd1, 5'd20, 3'b000, 5'd3));
    issue(op_word(7'h00, 5'd18, 5'd1, 3'b000, 5'd3));
    issue(op_word(7'h00, 5'd0, 5'd3, 3'b000, 5'd4));
    finish_test("illegal");
  endtask

  task automatic random_test(input int count);
    logic [31:0] kind;
    logic [31:0] rd;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] f3;
    logic [31:0] imm;
    logic [6:0]  f7;
    start_test();
    for (int n = 0; n < count; n++)
    begin
      kind = take_bits(4);
      rd   = take_bits(4);
      rs1  = take_bits(4);
      rs2  = take_bits(4);
      f3   = take_bits(3);
      if (kind < 6)
      begin
        imm = take_bits(12);
        if (f3[1:0] == 2'b01)
          imm[11:5] = (take_bits(2) == 0) ? 7'h20 : 7'h00;
        issue(imm_word(imm[11:0], rs1[4:0], f3[2:0], rd[4:0]));
      end
      else if (kind < 13)
      begin
        f7 = (take_bits(2) == 0) ? 7'h20 : 7'h00;
        issue(op_word(f7, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0]));
      end
      else if (kind < 15)
      begin
        imm = take_bits(20);
        issue(lui_word(imm[19:0], rd[4:0]));
      end
      else
        issue(take_bits(32));                   // Mostly unlisted opcodes
      idle(int'(take_bits(2)));
    end
    finish_test("random");
  endtask

  //////////////////////////////////////////////////
  // Main sequence

  initial
  begin
    rst         = 1'b1;
    imem_valid  = 1'b0;
    imem_parcel = 32'h0;
    for (int n = 0; n < 32; n++)
      xreg[n] = 32'h0;
    repeat (5) @(negedge clk);
    rst = 1'b0;

    imm_ops_test();
    reg_ops_test();
    bypass_test();
    x0_test();
    illegal_test();
    random_test(150);

    $display("Totals: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
rtl/core_pkg.sv
rtl/core_ifs.sv
rtl/rv_pd.sv
rtl/rv_id.sv
rtl/rv_regfile.sv
rtl/rv_ex.sv
rtl/rv_core.sv
bench/core_sva.sv
bench/tb_core.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench once per register file size

run_variant()
{
  local out
  out=$(verilator --binary --timing --assert -f src.f --top-module tb_core \
          -GRF_REGS="$1" --Mdir "obj_rf$1" 2>&1 && "./obj_rf$1/Vtb_core" 2>&1)
  echo "$out"
  echo "$out" | grep -qx "Result: PASSED"
}

run_variant 32 && run_variant 16 && echo "Both variants ran clean" || { echo "Run failed"; exit 1; }
